//--- src/buf_cfg_pkg.sv
// Buffer configuration package
// Sizes of the ping-pong operand buffer and its bank memories

package buf_cfg_pkg;

    // Width of one row word
    localparam int DATA_WIDTH = 16;

    // Rows per half bank, also pairs per block
    localparam int COL_X = 8;

    // Bank address width, covers both halves of a bank
    localparam int ADDR_WIDTH = 4;

    // Words per bank, low half for even rows and high half for odd rows
    localparam int BANK_DEPTH = 2 * COL_X;

    // Number of bank memories in the ping-pong pair
    localparam int NUM_BANKS = 2;

    // Width of the row index inside one half bank
    localparam int IDX_WIDTH = $clog2(COL_X);

    // Width of a bank number
    localparam int BANK_IDX_W = $clog2(NUM_BANKS);

endpackage

//--- src/pp_types_pkg.sv
// Ping-pong buffer types
// Bank roles, drain states, port requests and row pair payloads

package pp_types_pkg;

    import buf_cfg_pkg::*;

    // Role of bank 0, bank 1 always takes the other one
    typedef enum logic [0:0] {
        BANK0_FILL  = 1'b0,
        BANK0_DRAIN = 1'b1
    } bank_role_e;

    // Drain sweep state
    typedef enum logic [0:0] {
        DRAIN_IDLE = 1'b0,
        DRAIN_RUN  = 1'b1
    } drain_state_e;

    // One memory port request
    typedef struct packed {
        logic                  en;
        logic                  we;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
    } port_req_t;

    // Requests for both ports of one bank
    typedef struct packed {
        port_req_t port_a;
        port_req_t port_b;
    } bank_req_t;

    // Even row on port A, odd row on port B
    typedef struct packed {
        logic [DATA_WIDTH-1:0] row_a;
        logic [DATA_WIDTH-1:0] row_b;
    } row_pair_t;

    // Drained pair with the bank it came from
    typedef struct packed {
        row_pair_t             pair;
        logic [BANK_IDX_W-1:0] bank;
    } read_pair_t;

endpackage

//--- src/bank_ram.sv
// Bank memory
// True dual-port array with registered read data on both ports

module bank_ram
    import buf_cfg_pkg::*;
    import pp_types_pkg::*;
(
    input  logic                  clk,
    input  bank_req_t             req,
    output logic [DATA_WIDTH-1:0] rdata_a,
    output logic [DATA_WIDTH-1:0] rdata_b
);

    // Storage for both halves of the bank
    logic [DATA_WIDTH-1:0] mem [BANK_DEPTH];

    // Both ports share one process
    // Port A sits in the low half and port B in the high half, so they never collide
    always_ff @(posedge clk) begin
        // Port A write or read
        if (req.port_a.en) begin
            if (req.port_a.we) begin
                mem[req.port_a.addr] <= req.port_a.wdata;
            end else begin
                rdata_a <= mem[req.port_a.addr];
            end
        end

        // Port B write or read
        if (req.port_b.en) begin
            if (req.port_b.we) begin
                mem[req.port_b.addr] <= req.port_b.wdata;
            end else begin
                rdata_b <= mem[req.port_b.addr];
            end
        end
    end

endmodule

//--- src/fill_ctrl.sv
// Fill controller
// Writes accepted row pairs into the fill bank and flags a full block

module fill_ctrl
    import buf_cfg_pkg::*;
    import pp_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  row_pair_t in_pair,
    input  logic      fill_enable,
    output bank_req_t fill_req,
    output logic      fill_done
);

    // Beat count inside the current block
    logic [IDX_WIDTH-1:0] beat_cnt;
    logic                 accept;
    logic                 last_beat;

    // A beat is taken only while the fill side is open
    assign accept    = in_valid && fill_enable;
    assign last_beat = accept && (beat_cnt == IDX_WIDTH'(COL_X - 1));

    // Write requests formed straight from the accepted beat
    always_comb begin
        // Even row to the low half through port A
        fill_req.port_a.en    = accept;
        fill_req.port_a.we    = accept;
        fill_req.port_a.addr  = ADDR_WIDTH'(beat_cnt);
        fill_req.port_a.wdata = in_pair.row_a;

        // Odd row to the high half through port B
        fill_req.port_b.en    = accept;
        fill_req.port_b.we    = accept;
        fill_req.port_b.addr  = ADDR_WIDTH'(COL_X) + ADDR_WIDTH'(beat_cnt);
        fill_req.port_b.wdata = in_pair.row_b;
    end

    // Beat counter and block done flag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt  <= '0;
            fill_done <= 1'b0;
        end else begin
            // Pulse in the cycle after the last beat of a block
            fill_done <= last_beat;

            if (last_beat) begin
                // Wrap for the next block
                beat_cnt <= '0;
            end else if (accept) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

//--- src/drain_ctrl.sv
// Drain controller
// Sweeps a filled bank one pair per cycle and tags each pair with its bank

module drain_ctrl
    import buf_cfg_pkg::*;
    import pp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  drain_start,
    input  logic [BANK_IDX_W-1:0] drain_bank,
    input  row_pair_t             bank_rdata,
    output bank_req_t             drain_req,
    output logic                  out_valid,
    output read_pair_t            out_pair,
    output logic                  drain_done
);

    drain_state_e          state_q;
    logic [IDX_WIDTH-1:0]  idx_q;
    logic                  rd_issue;
    logic                  rd_last;

    // Read data handshake one memory latency behind the address
    logic                  rd_valid_q;
    logic                  rd_last_q;
    logic [BANK_IDX_W-1:0] rd_bank_q;

    // First read goes out in the start cycle itself
    assign rd_issue = drain_start || (state_q == DRAIN_RUN);
    assign rd_last  = rd_issue && (idx_q == IDX_WIDTH'(COL_X - 1));

    // Read only requests, write data unused
    always_comb begin
        drain_req.port_a.en    = rd_issue;
        drain_req.port_a.we    = 1'b0;
        drain_req.port_a.addr  = ADDR_WIDTH'(idx_q);
        drain_req.port_a.wdata = '0;

        // Matching odd row from the high half
        drain_req.port_b.en    = rd_issue;
        drain_req.port_b.we    = 1'b0;
        drain_req.port_b.addr  = ADDR_WIDTH'(COL_X) + ADDR_WIDTH'(idx_q);
        drain_req.port_b.wdata = '0;
    end

    // Sweep FSM and control pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= DRAIN_IDLE;
            idx_q      <= '0;
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            out_valid  <= 1'b0;
            drain_done <= 1'b0;
        end else begin
            if (rd_last) begin
                state_q <= DRAIN_IDLE;
                idx_q   <= '0;
            end else if (rd_issue) begin
                state_q <= DRAIN_RUN;
                idx_q   <= idx_q + 1'b1;
            end

            // Line up with registered memory data
            rd_valid_q <= rd_issue;
            rd_last_q  <= rd_last;

            // Output register stage
            out_valid  <= rd_valid_q;
            drain_done <= rd_last_q;
        end
    end

    // Payload path, tag follows the data through both stages
    always_ff @(posedge clk) begin
        rd_bank_q     <= drain_bank;
        out_pair.pair <= bank_rdata;
        out_pair.bank <= rd_bank_q;
    end

endmodule

//--- src/ping_pong_ctrl.sv
// Ping-pong controller
// Owns the bank roles, decides swaps and steers port traffic to the banks

module ping_pong_ctrl
    import buf_cfg_pkg::*;
    import pp_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  bank_req_t             fill_req,
    input  bank_req_t             drain_req,
    input  logic                  fill_done,
    input  logic                  drain_done,
    input  row_pair_t             bank0_rdata,
    input  row_pair_t             bank1_rdata,
    output bank_req_t             bank0_req,
    output bank_req_t             bank1_req,
    output logic                  fill_enable,
    output logic                  drain_start,
    output logic [BANK_IDX_W-1:0] drain_bank,
    output row_pair_t             bank_rdata
);

    // Role of bank 0
    bank_role_e role_q;

    // Fill bank is full and waits for the drain side
    logic full_q;

    // Drain sweep in flight, from swap up to drain_done
    logic drain_busy_q;

    // Fill side open for beats
    logic fill_open_q;

    // Swap request for this cycle
    logic swap;

    // Full block ready and drain side free or finishing now
    assign swap = (fill_done || full_q) && (!drain_busy_q || drain_done);

    // Closed right away in the fill_done cycle, no extra beat can slip in
    assign fill_enable = fill_open_q && !fill_done;

    // Role and swap bookkeeping
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            role_q       <= BANK0_FILL;
            full_q       <= 1'b0;
            drain_busy_q <= 1'b0;
            fill_open_q  <= 1'b0;
            drain_start  <= 1'b0;
        end else begin
            // Start pulse in the cycle the new roles take effect
            drain_start <= swap;

            if (swap) begin
                // Filled bank becomes the drain bank
                role_q      <= (role_q == BANK0_FILL) ? BANK0_DRAIN : BANK0_FILL;
                full_q      <= 1'b0;
                fill_open_q <= 1'b1;
            end else if (fill_done) begin
                // Hold the block until the drain side is idle
                full_q      <= 1'b1;
                fill_open_q <= 1'b0;
            end else if (!full_q) begin
                // Opens one cycle out of reset
                fill_open_q <= 1'b1;
            end

            // Busy from swap until the last pair leaves
            if (swap) begin
                drain_busy_q <= 1'b1;
            end else if (drain_done) begin
                drain_busy_q <= 1'b0;
            end
        end
    end

    // Request steering by role
    always_comb begin
        if (role_q == BANK0_FILL) begin
            bank0_req  = fill_req;
            bank1_req  = drain_req;
            bank_rdata = bank1_rdata;
        end else begin
            bank0_req  = drain_req;
            bank1_req  = fill_req;
            bank_rdata = bank0_rdata;
        end
    end

    // Bank number seen by the drain side
    assign drain_bank = (role_q == BANK0_DRAIN) ? BANK_IDX_W'(0) : BANK_IDX_W'(1);

endmodule

//--- src/pp_buffer_top.sv
// Ping-pong operand buffer top
// Fill and drain controllers around two bank memories

module pp_buffer_top
    import buf_cfg_pkg::*;
    import pp_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  row_pair_t  in_pair,
    output logic       in_ready,
    output logic       out_valid,
    output read_pair_t out_pair
);

    // Controller side requests
    bank_req_t fill_req;
    bank_req_t drain_req;

    // Bank side requests after steering
    bank_req_t bank0_req;
    bank_req_t bank1_req;

    // Handshake between the controllers
    logic                  fill_done;
    logic                  drain_done;
    logic                  fill_enable;
    logic                  drain_start;
    logic [BANK_IDX_W-1:0] drain_bank;

    // Read data per bank and from the drain bank
    row_pair_t bank0_rdata;
    row_pair_t bank1_rdata;
    row_pair_t bank_rdata;

    // Source may only offer beats while the fill side is open
    assign in_ready = fill_enable;

    fill_ctrl u_fill_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_pair     (in_pair),
        .fill_enable (fill_enable),
        .fill_req    (fill_req),
        .fill_done   (fill_done)
    );

    drain_ctrl u_drain_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .drain_start (drain_start),
        .drain_bank  (drain_bank),
        .bank_rdata  (bank_rdata),
        .drain_req   (drain_req),
        .out_valid   (out_valid),
        .out_pair    (out_pair),
        .drain_done  (drain_done)
    );

    ping_pong_ctrl u_ping_pong_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fill_req    (fill_req),
        .drain_req   (drain_req),
        .fill_done   (fill_done),
        .drain_done  (drain_done),
        .bank0_rdata (bank0_rdata),
        .bank1_rdata (bank1_rdata),
        .bank0_req   (bank0_req),
        .bank1_req   (bank1_req),
        .fill_enable (fill_enable),
        .drain_start (drain_start),
        .drain_bank  (drain_bank),
        .bank_rdata  (bank_rdata)
    );

    bank_ram u_bank0 (
        .clk     (clk),
        .req     (bank0_req),
        .rdata_a (bank0_rdata.row_a),
        .rdata_b (bank0_rdata.row_b)
    );

    bank_ram u_bank1 (
        .clk     (clk),
        .req     (bank1_req),
        .rdata_a (bank1_rdata.row_a),
        .rdata_b (bank1_rdata.row_b)
    );

endmodule

//--- sim/pp_buffer_properties.sv
// Ping-pong controller properties
// Bank write exclusion, swap ordering and fill gating around a swap

module pp_buffer_properties
    import pp_types_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input bank_req_t bank0_req,
    input bank_req_t bank1_req,
    input logic      fill_done,
    input logic      drain_done,
    input logic      drain_start,
    input logic      fill_enable
);
    timeunit 1ns;
    timeprecision 1ps;

    // Failed property count, watched by the testbench
    int prop_fail_cnt = 0;

    logic bank0_wr;
    logic bank1_wr;

    // Completed fill not yet handed to the drain side
    logic fill_seen;

    // Drain sweep in flight, from drain_start up to drain_done
    logic drain_run;

    // A bank is written when either port carries a write
    assign bank0_wr = (bank0_req.port_a.en && bank0_req.port_a.we) ||
                      (bank0_req.port_b.en && bank0_req.port_b.we);
    assign bank1_wr = (bank1_req.port_a.en && bank1_req.port_a.we) ||
                      (bank1_req.port_b.en && bank1_req.port_b.we);

    // Handover model built from the strobes alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_seen <= 1'b0;
            drain_run <= 1'b0;
        end else begin
            if (fill_done) begin
                fill_seen <= 1'b1;
            end else if (drain_start) begin
                fill_seen <= 1'b0;
            end

            if (drain_start) begin
                drain_run <= 1'b1;
            end else if (drain_done) begin
                drain_run <= 1'b0;
            end
        end
    end

    // Only the fill bank ever takes writes
    single_bank_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(bank0_wr && bank1_wr))
    else begin
        $error("both banks received write requests in one cycle");
        prop_fail_cnt++;
    end

    // Drain start needs a full block behind it
    start_after_fill: assert property (@(posedge clk) disable iff (!rst_n)
        drain_start |-> $past(fill_done || fill_seen))
    else begin
        $error("drain_start without a completed fill");
        prop_fail_cnt++;
    end

    // and a drain side that is idle or just finishing
    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        drain_start |-> $past(!drain_run || drain_done))
    else begin
        $error("drain_start while a drain was still running");
        prop_fail_cnt++;
    end

    // Fill side stays closed from fill_done up to the swap
    closed_until_swap: assert property (@(posedge clk) disable iff (!rst_n)
        (fill_done || (fill_seen && !drain_start)) |-> !fill_enable)
    else begin
        $error("fill_enable high between fill_done and the swap");
        prop_fail_cnt++;
    end

endmodule

bind ping_pong_ctrl pp_buffer_properties u_pp_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .bank0_req    (bank0_req),
    .bank1_req    (bank1_req),
    .fill_done    (fill_done),
    .drain_done   (drain_done),
    .drain_start  (drain_start),
    .fill_enable  (fill_enable)
);

//--- sim/tb_pp_buffer.sv
// Ping-pong buffer testbench
// Directed tests against a queue of accepted pairs with their expected bank

module tb_pp_buffer
    import buf_cfg_pkg::*;
    import pp_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Ten blocks in all, each well under 40 cycles even with random gaps
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int SEED = 32'h1500_a70e;
    // Marker pair offered only while in_ready is low
    localparam row_pair_t DROP_PAIR = '{row_a: 16'hdead, row_b: 16'hbeef};

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    row_pair_t  in_pair;
    logic       in_ready;
    logic       out_valid;
    read_pair_t out_pair;

    // Reference model of accepted pairs in arrival order
    read_pair_t exp_q[$];
    int cycle_cnt = 0;
    // Beats since the last reset, sets the expected bank
    int accepted_cnt = 0;
    int total_in = 0;
    int total_out = 0;
    int blocked_offers = 0;
    int last_taken_cycle = 0;

    pp_buffer_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pair   (in_pair),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pair  (out_pair)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Cycle count and hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("Timeout: the run hung for %0d cycles", cycle_cnt));
        end
    end

    // Bound property failures end the run at once
    always @(negedge clk) begin
        assert (dut.u_ping_pong_ctrl.u_pp_props.prop_fail_cnt == 0) else begin
            report_failure("Bound property check on the ping-pong controller failed");
        end
    end

    // Scoreboard, sampled mid cycle where all DUT signals are settled
    always @(negedge clk) begin : scoreboard
        read_pair_t expected;
        if (!rst_n) begin
            accepted_cnt = 0;
        end else begin
            // Accepted beat, bank alternates per block of COL_X pairs
            if (in_valid && in_ready) begin
                expected.pair = in_pair;
                expected.bank = BANK_IDX_W'((accepted_cnt / COL_X) % NUM_BANKS);
                exp_q.push_back(expected);
                accepted_cnt++;
                total_in++;
            end
            if (out_valid) begin
                assert (exp_q.size() != 0) else begin
                    report_failure("out_valid raised with no accepted pair left to drain");
                end
                expected = exp_q.pop_front();
                check_value("out_pair.pair.row_a", expected.pair.row_a, out_pair.pair.row_a);
                check_value("out_pair.pair.row_b", expected.pair.row_b, out_pair.pair.row_b);
                check_value("out_pair.bank", expected.bank, out_pair.bank);
                total_out++;
            end
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("MISMATCH %s: expected %h, got %h", name, expected, actual));
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n    <= 1'b0;
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // Offer one pair until taken, returns before the accept edge
    task automatic send_beat(input row_pair_t pair);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_pair  <= pair;
            @(negedge clk);
            taken = in_ready;
            if (!taken) begin
                blocked_offers++;
            end
        end
        last_taken_cycle = cycle_cnt;
    endtask

    // Even rows on row_a, odd rows on row_b
    task automatic send_block(input logic [DATA_WIDTH-1:0] base);
        row_pair_t pair;
        for (int k = 0; k < COL_X; k++) begin
            pair.row_a = base + DATA_WIDTH'(2 * k);
            pair.row_b = base + DATA_WIDTH'(2 * k + 1);
            send_beat(pair);
        end
    endtask

    // Marker beats in cycles where in_ready must be low
    task automatic offer_dropped(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b1;
            in_pair  <= DROP_PAIR;
            @(negedge clk);
            check_value("in_ready", 0, in_ready);
        end
    endtask

    task automatic wait_drained();
        do begin
            @(negedge clk);
        end while (exp_q.size() != 0);
        idle_cycles(3);
    endtask

    task automatic after_reset_levels();
        apply_reset();
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 0, in_ready);
        // Fill side opens one cycle after release
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        check_value("in_ready", 1, in_ready);
    endtask

    task automatic single_block_order();
        apply_reset();
        send_block(16'h1000);
        idle_cycles(1);
        do begin
            @(negedge clk);
        end while (!out_valid);
        check_value("out_valid delay", 4, cycle_cnt - last_taken_cycle);
        // Whole block on consecutive cycles, then silence
        repeat (COL_X - 1) begin
            @(negedge clk);
            check_value("out_valid", 1, out_valid);
        end
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        wait_drained();
    endtask

    task automatic back_to_back_blocks();
        int blocked_before;
        apply_reset();
        send_block(16'h2000);
        send_block(16'h3000);
        blocked_before = blocked_offers;
        // Third block waits while one bank drains and the other holds a full block
        send_block(16'h4000);
        check_value("in_ready low cycles", 2, blocked_offers - blocked_before);
        idle_cycles(1);
        wait_drained();
    endtask

    task automatic blocked_beats_dropped();
        int out_before;
        apply_reset();
        out_before = total_out;
        send_block(16'h5000);
        offer_dropped(1);
        send_block(16'h6000);
        // Both banks occupied until the first drain ends
        offer_dropped(2);
        idle_cycles(1);
        wait_drained();
        check_value("drained pairs", 2 * COL_X, total_out - out_before);
    endtask

    task automatic random_gap_stream();
        row_pair_t pair;
        int out_before;
        apply_reset();
        out_before = total_out;
        for (int i = 0; i < 4 * COL_X; i++) begin
            idle_cycles($urandom_range(3));
            pair = row_pair_t'($urandom());
            send_beat(pair);
        end
        idle_cycles(1);
        wait_drained();
        check_value("drained pairs", 4 * COL_X, total_out - out_before);
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_pair  = '0;
        void'($urandom(SEED));
        after_reset_levels();
        single_block_order();
        back_to_back_blocks();
        blocked_beats_dropped();
        random_gap_stream();
        assert (exp_q.size() == 0) else begin
            report_failure("Accepted pairs never came out of the buffer");
        end
        check_value("total pairs", total_in, total_out);
        if (dut.u_ping_pong_ctrl.u_pp_props.prop_fail_cnt == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_failure("Bound property checks on the ping-pong controller failed");
        end
    end

endmodule

//--- sim.f
src/buf_cfg_pkg.sv
src/pp_types_pkg.sv
src/bank_ram.sv
src/fill_ctrl.sv
src/drain_ctrl.sv
src/ping_pong_ctrl.sv
src/pp_buffer_top.sv
sim/pp_buffer_properties.sv
sim/tb_pp_buffer.sv
